/* src.f */
design/tlul_pkg.sv
design/tlul_host_adapter.sv
design/tlul_sram_device.sv
design/tlul_sram_subsystem.sv
testbench/tb_checker.sv
testbench/tlul_props.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the TL-UL memory testbench with Verilator and runs it
# the run passes only when the log holds the pass line of the testbench

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_top_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module tb_top \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG_FILE"; then
    exit 0
else
    echo "pass line not found in $LOG_FILE"
    exit 1
fi

/* testbench/tb_top.sv */
`timescale 1ns/1ns

module tb_top;

    import tlul_pkg::*;

    localparam int unsigned N_TRANS    = 2000;
    localparam int unsigned MEM_WORDS  = 64;
    localparam int unsigned MAX_REQS   = 2;
    localparam int unsigned CLK_PERIOD = 8;
    // word index drawn over twice the memory so that errors occur
    localparam int unsigned IDX_BITS   = $clog2(2 * MEM_WORDS);
    localparam int unsigned TIMEOUT_NS = (N_TRANS + MEM_WORDS) * 4 * CLK_PERIOD;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       req_i;
    logic       gnt_o;
    tl_addr_t   addr_i;
    logic       we_i;
    tl_data_t   wdata_i;
    tl_mask_t   be_i;
    logic       valid_o;
    tl_data_t   rdata_o;
    logic       err_o;
    int         err_cnt;
    int         pending;
    logic [31:0] lfsr_q = 32'hc81e_21fb;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    tlul_sram_subsystem #(
        .MAX_REQS  (MAX_REQS),
        .MEM_WORDS (MEM_WORDS)
    ) tlul_sram_subsystem_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (req_i),
        .gnt_o   (gnt_o),
        .addr_i  (addr_i),
        .we_i    (we_i),
        .wdata_i (wdata_i),
        .be_i    (be_i),
        .valid_o (valid_o),
        .rdata_o (rdata_o),
        .err_o   (err_o)
    );

    tb_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) tb_checker_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (req_i),
        .gnt_i     (gnt_o),
        .addr_i    (addr_i),
        .we_i      (we_i),
        .wdata_i   (wdata_i),
        .be_i      (be_i),
        .valid_i   (valid_o),
        .rdata_i   (rdata_o),
        .err_i     (err_o),
        .err_cnt_o (err_cnt),
        .pending_o (pending)
    );

    // one step of a Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // gathers n random bits, stepping the LFSR once for each
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] value;
        value = '0;
        for (int unsigned i = 0; i < n; i++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return value;
    endfunction

    // called 1 ns after a rising edge, returns 1 ns after the granting edge
    task automatic drive_req(input tl_addr_t addr, input logic we, input tl_data_t wdata,
                             input tl_mask_t be);
        logic granted;
        granted = 1'b0;
        req_i   = 1'b1;
        addr_i  = addr;
        we_i    = we;
        wdata_i = wdata;
        be_i    = be;
        // the request stays on the bus until a cycle with gnt_o high
        while (!granted) begin
            @(negedge clk_i);
            granted = gnt_o;
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic idle_cycle();
        req_i = 1'b0;
        @(posedge clk_i);
        #1;
    endtask

    initial begin : stimulus
        logic [31:0] idx;
        logic [31:0] low;
        logic        we;
        tl_data_t    wdata;
        tl_mask_t    be;
        rst_ni  = 1'b0;
        req_i   = 1'b0;
        addr_i  = '0;
        we_i    = 1'b0;
        wdata_i = '0;
        be_i    = '0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // fill every word first so that all later reads are defined
        for (int unsigned w = 0; w < MEM_WORDS; w++) begin
            drive_req(tl_addr_t'(w * 4), 1'b1, rand_bits(32), 4'hf);
        end
        for (int unsigned t = 0; t < N_TRANS; t++) begin
            if (rand_bits(1) == 32'd1) begin
                // the fields are drawn one after another so the sequence is fixed
                idx   = rand_bits(IDX_BITS);
                low   = rand_bits(2);
                we    = rand_bits(1) == 32'd1;
                wdata = rand_bits(32);
                be    = tl_mask_t'(rand_bits(4));
                drive_req((idx << 2) | low, we, wdata, be);
            end else begin
                idle_cycle();
            end
        end
        // the last response lands one cycle after its grant
        idle_cycle();
        idle_cycle();
        $display("closing count: %0d checker errors, %0d responses still missing",
                 err_cnt, pending);
        if (err_cnt == 0 && pending == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("the run timed out after %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* testbench/tlul_props.sv */
`timescale 1ns/1ns

// protocol checks on the link between the adapter and the device
module tlul_props #(
    parameter int unsigned MAX_REQS = 2
) (
    input logic              clk_i,
    input logic              rst_ni,
    input tlul_pkg::tl_h2d_t tl_a_i,
    input tlul_pkg::tl_d2h_t tl_d_i
);

    import tlul_pkg::*;

    logic       a_accept;
    tl_source_t exp_source_q;

    assign a_accept = tl_a_i.a_valid && tl_d_i.a_ready;

    // next source id that the adapter should send, wrapping at MAX_REQS
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            exp_source_q <= '0;
        end else if (a_accept) begin
            if (exp_source_q == TL_AIW'(MAX_REQS - 1)) begin
                exp_source_q <= '0;
            end else begin
                exp_source_q <= exp_source_q + tl_source_t'(1);
            end
        end
    end

    get_full_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (tl_a_i.a_valid && tl_a_i.a_opcode == Get) |-> (&tl_a_i.a_mask))
        else $error("Get beat carries a partial mask");

    word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tl_a_i.a_valid |-> (tl_a_i.a_address[1:0] == 2'b00))
        else $error("channel A address is not word aligned");

    ack_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        a_accept |=> tl_d_i.d_valid)
        else $error("accepted beat got no d_valid on the next cycle");

    // the D beat echoes source and size of the beat accepted one cycle earlier
    // and acknowledges a Get with data, a Put without
    d_echo: assert property (@(posedge clk_i) disable iff (!rst_ni)
        a_accept |=> ((tl_d_i.d_source == $past(tl_a_i.a_source))
            && (tl_d_i.d_size == $past(tl_a_i.a_size))
            && (tl_d_i.d_opcode == (($past(tl_a_i.a_opcode) == Get) ? AccessAckData
                                                                    : AccessAck))))
        else $error("D beat does not match the beat accepted before it");

    // a cycle in reset clears the response register on that edge
    no_d_in_reset: assert property (@(posedge clk_i)
        !rst_ni |=> !tl_d_i.d_valid)
        else $error("d_valid high after a reset cycle");

    source_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        a_accept |-> (tl_a_i.a_source == exp_source_q))
        else $error("accepted source id out of sequence");

endmodule

bind tlul_sram_subsystem tlul_props #(
    .MAX_REQS (MAX_REQS)
) tlul_props_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tl_a_i (tl_a),
    .tl_d_i (tl_d)
);

/* testbench/tb_checker.sv */
`timescale 1ns/1ns

// watches the host side of the subsystem and checks every response
// against a reference memory kept here
module tb_checker #(
    parameter int unsigned MEM_WORDS = 64
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               req_i,
    input  logic               gnt_i,
    input  tlul_pkg::tl_addr_t addr_i,
    input  logic               we_i,
    input  tlul_pkg::tl_data_t wdata_i,
    input  tlul_pkg::tl_mask_t be_i,
    input  logic               valid_i,
    input  tlul_pkg::tl_data_t rdata_i,
    input  logic               err_i,
    output int                 err_cnt_o,
    output int                 pending_o
);

    import tlul_pkg::*;

    localparam int unsigned MemAw = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    // one expected response, data only matters for reads
    typedef struct packed {
        logic     is_read;
        logic     err;
        tl_data_t data;
    } exp_rsp_t;

    tl_data_t ref_mem [MEM_WORDS];
    exp_rsp_t rsp_q [$];
    logic     granted_q = 1'b0;
    int       since_reset = 0;

    initial begin
        err_cnt_o = 0;
        pending_o = 0;
    end

    // sampling on the falling edge sees every DUT output settled
    always @(negedge clk_i) begin : watch
        exp_rsp_t         expected;
        logic [31:0]      word_idx;
        logic [MemAw-1:0] word;
        if (!rst_ni) begin
            since_reset = 0;
            granted_q   = 1'b0;
            // nothing may be granted or answered while in reset
            if (gnt_i !== 1'b0 || valid_i !== 1'b0) begin
                $display("gnt_o or valid_o was high during reset at %0t ns", $time);
                err_cnt_o++;
            end
        end else begin
            if (since_reset < 3) begin
                since_reset++;
            end
            // a_ready comes up on the first edge that sees reset released
            if (since_reset == 2 && gnt_i !== 1'b1) begin
                $display("gnt_o was not high on the first cycle after reset");
                err_cnt_o++;
            end
            if (valid_i === 1'b1) begin
                if (rsp_q.size() == 0) begin
                    $display("unexpected response at %0t ns with no request pending", $time);
                    err_cnt_o++;
                end else begin
                    expected = rsp_q.pop_front();
                    if (!granted_q) begin
                        $display("response at %0t ns came later than one cycle after its grant",
                                 $time);
                        err_cnt_o++;
                    end
                    if (err_i !== expected.err) begin
                        $display("error at %0t ns: err_o is %b, expected %b",
                                 $time, err_i, expected.err);
                        err_cnt_o++;
                    end
                    if (expected.is_read && rdata_i !== expected.data) begin
                        $display("error at %0t ns: rdata_o is %h, expected %h",
                                 $time, rdata_i, expected.data);
                        err_cnt_o++;
                    end
                end
            end else if (granted_q) begin
                $display("missing response at %0t ns, no valid_o one cycle after a grant",
                         $time);
                err_cnt_o++;
                // the lost response would never arrive, drop it to stay in step
                if (rsp_q.size() > 0) begin
                    void'(rsp_q.pop_front());
                end
            end
            granted_q = (req_i === 1'b1) && (gnt_i === 1'b1);
            if (granted_q) begin
                // the byte offset is ignored, only the word index counts
                word_idx         = {2'b00, addr_i[TL_AW-1:2]};
                word             = word_idx[MemAw-1:0];
                expected.is_read = !we_i;
                expected.err     = word_idx >= MEM_WORDS;
                expected.data    = '0;
                if (!expected.err) begin
                    if (we_i) begin
                        for (int lane = 0; lane < 4; lane++) begin
                            if (be_i[lane]) begin
                                ref_mem[word][8*lane +: 8] = wdata_i[8*lane +: 8];
                            end
                        end
                    end else begin
                        expected.data = ref_mem[word];
                    end
                end
                rsp_q.push_back(expected);
            end
        end
        pending_o = rsp_q.size();
    end

endmodule

/* design/tlul_sram_subsystem.sv */
`timescale 1ns/1ns

// host adapter and memory device joined by a single TL-UL link
// MAX_REQS sizes the adapter's source ids, MEM_WORDS the memory depth
module tlul_sram_subsystem #(
    parameter int unsigned MAX_REQS  = 2,
    parameter int unsigned MEM_WORDS = 64
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               req_i,
    output logic               gnt_o,
    input  tlul_pkg::tl_addr_t addr_i,
    input  logic               we_i,
    input  tlul_pkg::tl_data_t wdata_i,
    input  tlul_pkg::tl_mask_t be_i,
    output logic               valid_o,
    output tlul_pkg::tl_data_t rdata_o,
    output logic               err_o
);

    import tlul_pkg::*;

    // channel A plus d_ready towards the device
    tl_h2d_t tl_a;
    // channel D plus a_ready back to the adapter
    tl_d2h_t tl_d;

    tlul_host_adapter #(
        .MAX_REQS (MAX_REQS)
    ) tlul_host_adapter_i (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (req_i),
        .gnt_o    (gnt_o),
        .addr_i   (addr_i),
        .we_i     (we_i),
        .wdata_i  (wdata_i),
        .be_i     (be_i),
        .valid_o  (valid_o),
        .rdata_o  (rdata_o),
        .err_o    (err_o),
        .tl_h_c_a (tl_a),
        .tl_h_c_d (tl_d)
    );

    tlul_sram_device #(
        .MEM_WORDS (MEM_WORDS)
    ) tlul_sram_device_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .tl_i   (tl_a),
        .tl_o   (tl_d)
    );

endmodule

/* design/tlul_sram_device.sv */
`timescale 1ns/1ns

// TL-UL device in front of a word memory
// every accepted beat is answered on channel D exactly one cycle later,
// so responses leave in the order the requests came in
module tlul_sram_device #(
    parameter int unsigned MEM_WORDS = 64
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  tlul_pkg::tl_h2d_t tl_i,
    output tlul_pkg::tl_d2h_t tl_o
);

    import tlul_pkg::*;

    localparam int unsigned WordSize = $clog2(TL_DBW);
    // word index as carried on the bus, wider than the memory needs
    localparam int unsigned IdxW     = TL_AW - WordSize;
    // index width into the memory itself, at least one bit
    localparam int unsigned MemAw    = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    tl_data_t mem [MEM_WORDS];

    logic             a_ready_q;
    logic             a_ack;
    logic [IdxW-1:0]  word_idx;
    logic [MemAw-1:0] mem_idx;
    logic             in_range;
    logic             size_ok;
    logic             req_err;
    logic             is_get;
    logic             is_put;
    logic             mem_we;
    tl_data_t         rdata;

    // response register, d_valid is the only part that needs a reset
    logic              d_valid_q;
    tl_d_op_e          d_opcode_q;
    logic [TL_SZW-1:0] d_size_q;
    tl_source_t        d_source_q;
    tl_data_t          d_data_q;
    logic              d_error_q;

    // the response stage drains every cycle and d_ready stays high,
    // so a_ready only has to come up once reset is released
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            a_ready_q <= 1'b0;
        end else begin
            a_ready_q <= 1'b1;
        end
    end

    assign a_ack = tl_i.a_valid && a_ready_q;

    // the bits above the byte lanes select the word
    assign word_idx = tl_i.a_address[TL_AW-1:WordSize];
    assign mem_idx  = word_idx[MemAw-1:0];
    assign in_range = word_idx < IdxW'(MEM_WORDS);

    // only whole-word accesses are supported
    assign size_ok = tl_i.a_size == TL_SZW'(WordSize);
    assign req_err = !in_range || !size_ok;

    assign is_get = tl_i.a_opcode == Get;
    assign is_put = (tl_i.a_opcode == PutFullData) || (tl_i.a_opcode == PutPartialData);

    // an error beat must leave the memory untouched
    assign mem_we = a_ack && is_put && !req_err;

    // out of range reads see the truncated index but the data is dropped below
    assign rdata = mem[mem_idx];

    // the write lands on the same edge that accepts the beat
    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            for (int unsigned lane = 0; lane < TL_DBW; lane++) begin
                if (tl_i.a_mask[lane]) begin
                    mem[mem_idx][8*lane +: 8] <= tl_i.a_data[8*lane +: 8];
                end
            end
        end
    end

    // one beat on D per accepted beat on A, valid for a single cycle
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            d_valid_q <= 1'b0;
        end else begin
            d_valid_q <= a_ack;
        end
    end

    // payload is captured only when a beat is accepted
    always_ff @(posedge clk_i) begin
        if (a_ack) begin
            d_opcode_q <= is_get ? AccessAckData : AccessAck;
            d_size_q   <= tl_i.a_size;
            d_source_q <= tl_i.a_source;
            d_error_q  <= req_err;
            // writes and failed reads come back with zero data
            if (is_get && !req_err) begin
                d_data_q <= rdata;
            end else begin
                d_data_q <= '0;
            end
        end
    end

    assign tl_o = '{
        d_valid:  d_valid_q,
        d_opcode: d_opcode_q,
        d_size:   d_size_q,
        d_source: d_source_q,
        d_data:   d_data_q,
        d_error:  d_error_q,
        a_ready:  a_ready_q
    };

endmodule

/* design/tlul_host_adapter.sv */
`timescale 1ns/1ns

// turns a plain req/gnt/valid host into TL-UL channel A beats and hands
// channel D straight back to the host
// the host must keep no more than MAX_REQS requests in flight
module tlul_host_adapter #(
    parameter int unsigned MAX_REQS = 2
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                req_i,
    output logic                gnt_o,
    input  tlul_pkg::tl_addr_t  addr_i,
    input  logic                we_i,
    input  tlul_pkg::tl_data_t  wdata_i,
    input  tlul_pkg::tl_mask_t  be_i,
    output logic                valid_o,
    output tlul_pkg::tl_data_t  rdata_o,
    output logic                err_o,
    output tlul_pkg::tl_h2d_t   tl_h_c_a,
    input  tlul_pkg::tl_d2h_t   tl_h_c_d
);

    import tlul_pkg::*;

    // log2 of the bytes in a word, used both as size and as alignment
    localparam int unsigned WordSize = $clog2(TL_DBW);

    tl_source_t tl_source;
    tl_mask_t   tl_mask;
    tl_a_op_e   tl_opcode;
    tl_addr_t   tl_address;

    if (MAX_REQS > 1) begin : g_source_cnt
        localparam int unsigned ReqNumW = $clog2(MAX_REQS);

        logic [ReqNumW-1:0] source_q;

        // one source id per request, wrapping at MAX_REQS
        always_ff @(posedge clk_i) begin
            if (!rst_ni) begin
                source_q <= '0;
            end else if (req_i && gnt_o) begin
                if (source_q == ReqNumW'(MAX_REQS - 1)) begin
                    source_q <= '0;
                end else begin
                    source_q <= source_q + 1'b1;
                end
            end
        end

        assign tl_source = TL_AIW'(source_q);
    end else begin : g_source_zero
        // a single request in flight needs no id to tell responses apart
        assign tl_source = '0;
    end

    // TL-UL wants every lane set on a Get, writes use the host enables
    assign tl_mask = we_i ? be_i : {TL_DBW{1'b1}};

    always_comb begin
        if (!we_i) begin
            tl_opcode = Get;
        end else if (&be_i) begin
            tl_opcode = PutFullData;
        end else begin
            tl_opcode = PutPartialData;
        end
    end

    // drop the byte offset, the device only works on whole words
    assign tl_address = {addr_i[TL_AW-1:WordSize], {WordSize{1'b0}}};

    assign tl_h_c_a = '{
        a_valid:   req_i,
        a_opcode:  tl_opcode,
        a_param:   3'h0,
        a_size:    TL_SZW'(WordSize),
        a_mask:    tl_mask,
        a_source:  tl_source,
        a_address: tl_address,
        a_data:    wdata_i,
        d_ready:   1'b1
    };

    // channel D is never stalled, so responses go straight to the host
    assign gnt_o   = tl_h_c_d.a_ready;
    assign valid_o = tl_h_c_d.d_valid;
    assign rdata_o = tl_h_c_d.d_data;
    assign err_o   = tl_h_c_d.d_error;

endmodule

/* design/tlul_pkg.sv */
package tlul_pkg;

    // bus widths for a word-wide TL-UL link
    parameter int unsigned TL_AW  = 32;
    parameter int unsigned TL_DW  = 32;
    // one mask bit per byte lane of a data word
    parameter int unsigned TL_DBW = TL_DW / 8;
    parameter int unsigned TL_AIW = 8;
    parameter int unsigned TL_SZW = 2;

    // byte address as it appears on channel A
    typedef logic [TL_AW-1:0]  tl_addr_t;
    // one data word, the only access size used here
    typedef logic [TL_DW-1:0]  tl_data_t;
    typedef logic [TL_DBW-1:0] tl_mask_t;
    // source id that pairs a response with its request
    typedef logic [TL_AIW-1:0] tl_source_t;

    // channel A opcodes, encodings as in the TL-UL specification
    typedef enum logic [2:0] {
        PutFullData    = 3'h0,
        PutPartialData = 3'h1,
        Get            = 3'h4
    } tl_a_op_e;

    // channel D opcodes, data only comes back with a Get
    typedef enum logic [2:0] {
        AccessAck     = 3'h0,
        AccessAckData = 3'h1
    } tl_d_op_e;

    // everything the host drives, channel A plus the D ready
    typedef struct packed {
        logic              a_valid;
        tl_a_op_e          a_opcode;
        logic [2:0]        a_param;
        logic [TL_SZW-1:0] a_size;
        tl_mask_t          a_mask;
        tl_source_t        a_source;
        tl_addr_t          a_address;
        tl_data_t          a_data;
        logic              d_ready;
    } tl_h2d_t;

    // everything the device drives, channel D plus the A ready
    typedef struct packed {
        logic              d_valid;
        tl_d_op_e          d_opcode;
        logic [TL_SZW-1:0] d_size;
        tl_source_t        d_source;
        tl_data_t          d_data;
        logic              d_error;
        logic              a_ready;
    } tl_d2h_t;

endpackage
